//--- hw/rv_subset_pkg.sv
package rv_subset_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and reset values
  //////////////////////////////////////////////////////////////////////

  // data and address width
  localparam int xlen = 32;
  // register index width
  localparam int reg_addr_w = 5;
  // pc after reset
  localparam logic [xlen-1:0] boot_addr = 32'h0000_0000;

  //////////////////////////////////////////////////////////////////////
  // encodings of the supported subset
  //////////////////////////////////////////////////////////////////////

  // major opcodes, bits 6:0
  localparam logic [6:0] opcode_alur   = 7'b0110011;
  localparam logic [6:0] opcode_alui   = 7'b0010011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;

  // funct3, bits 14:12
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_addi    = 3'b000;
  localparam logic [2:0] funct3_beq     = 3'b000;

  // funct7, bits 31:25
  localparam logic [6:0] funct7_sub = 7'b0100000;
  localparam logic [6:0] funct7_or  = 7'b0000000;

  // operations after decode
  typedef enum logic [2:0] {
    op_sub,
    op_or,
    op_addi,
    op_beq,
    op_jal,
    op_jalr,
    op_illegal
  } op_e;

  // decoder output, imm already sign-extended
  typedef struct packed {
    op_e                   op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
  } decoded_t;

  // execute result for one instruction
  typedef struct packed {
    logic            wb_en;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] next_pc;
  } exec_result_t;

  // trace record, 135 bits
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       instr;
    logic [reg_addr_w-1:0] rd;
    logic                  wb_en;
    logic [xlen-1:0]       wb_data;
    logic [xlen-1:0]       next_pc;
    logic                  illegal;
  } retire_t;

endpackage

//--- hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic [rv_subset_pkg::xlen-1:0] instr_i,
  output rv_subset_pkg::decoded_t        dec_o
);
  import rv_subset_pkg::*;

  // fixed fields of the word
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  // immediates per format
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // i-type takes 12 bits from the top
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  // b-type 13-bit offset with lsb always zero
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  // j-type 21-bit offset with lsb always zero
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // register fields sit in the same place for every format
    dec_o.op  = op_illegal;
    dec_o.rd  = instr_i[11:7];
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];
    dec_o.imm = '0;
    case (opcode)
      opcode_alur: begin
        // only sub and or out of the r-type group
        if (funct3 == funct3_add_sub && funct7 == funct7_sub) begin
          dec_o.op = op_sub;
        end else if (funct3 == funct3_or && funct7 == funct7_or) begin
          dec_o.op = op_or;
        end
      end
      opcode_alui: begin
        if (funct3 == funct3_addi) begin
          dec_o.op  = op_addi;
          dec_o.imm = imm_i;
        end
      end
      opcode_branch: begin
        if (funct3 == funct3_beq) begin
          dec_o.op  = op_beq;
          dec_o.imm = imm_b;
        end
      end
      opcode_jal: begin
        dec_o.op  = op_jal;
        dec_o.imm = imm_j;
      end
      opcode_jalr: begin
        // jalr decoded on the opcode alone
        dec_o.op  = op_jalr;
        dec_o.imm = imm_i;
      end
      default: begin
        dec_o.op = op_illegal;
      end
    endcase
  end

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  rv_subset_pkg::decoded_t        dec_i,
  input  logic [rv_subset_pkg::xlen-1:0] pc_i,
  input  logic [rv_subset_pkg::xlen-1:0] rs1_data_i,
  input  logic [rv_subset_pkg::xlen-1:0] rs2_data_i,
  output rv_subset_pkg::exec_result_t    res_o
);
  import rv_subset_pkg::*;

  // shared adders
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_plus_imm;
  logic [xlen-1:0] rs1_plus_imm;
  // beq compare
  logic            src_equal;

  assign pc_plus4     = pc_i + 32'd4;
  assign pc_plus_imm  = pc_i + dec_i.imm;
  assign rs1_plus_imm = rs1_data_i + dec_i.imm;
  assign src_equal    = (rs1_data_i == rs2_data_i);

  always_comb begin
    // default is fall-through with no write
    res_o.wb_en   = 1'b0;
    res_o.wb_data = '0;
    res_o.next_pc = pc_plus4;
    case (dec_i.op)
      op_sub: begin
        res_o.wb_en   = 1'b1;
        res_o.wb_data = rs1_data_i - rs2_data_i;
      end
      op_or: begin
        res_o.wb_en   = 1'b1;
        res_o.wb_data = rs1_data_i | rs2_data_i;
      end
      op_addi: begin
        res_o.wb_en   = 1'b1;
        res_o.wb_data = rs1_plus_imm;
      end
      op_beq: begin
        // branch writes no register
        if (src_equal) begin
          res_o.next_pc = pc_plus_imm;
        end
      end
      op_jal: begin
        res_o.wb_en   = 1'b1;
        res_o.wb_data = pc_plus4;
        res_o.next_pc = pc_plus_imm;
      end
      op_jalr: begin
        res_o.wb_en   = 1'b1;
        res_o.wb_data = pc_plus4;
        // target lsb cleared
        res_o.next_pc = {rs1_plus_imm[xlen-1:1], 1'b0};
      end
      default: begin
        // illegal, retires as a no-op
        res_o.wb_en = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                                 clk_i,
  input  logic                                 rstn_i,
  input  logic                                 we_i,
  input  logic [rv_subset_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [rv_subset_pkg::xlen-1:0]       wdata_i,
  input  logic [rv_subset_pkg::reg_addr_w-1:0] raddr1_i,
  input  logic [rv_subset_pkg::reg_addr_w-1:0] raddr2_i,
  output logic [rv_subset_pkg::xlen-1:0]       rdata1_o,
  output logic [rv_subset_pkg::xlen-1:0]       rdata2_o
);
  import rv_subset_pkg::*;

  // x0 entry exists but is never written
  logic [xlen-1:0] regs_q [2**reg_addr_w];

  ////////////////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // read ports, combinational
  ////////////////////////////////////////////////////////////////////////

  // index zero forced to zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

//--- hw/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
  input  logic                           clk_i,
  input  logic                           rstn_i,
  output logic                           imem_req_o,
  output logic [rv_subset_pkg::xlen-1:0] imem_addr_o,
  input  logic                           imem_ack_i,
  input  logic [rv_subset_pkg::xlen-1:0] imem_rdata_i,
  output logic [rv_subset_pkg::xlen-1:0] instr_o,
  output logic [rv_subset_pkg::xlen-1:0] pc_o,
  input  rv_subset_pkg::decoded_t        dec_i,
  input  rv_subset_pkg::exec_result_t    res_i,
  output logic                           rf_we_o,
  output logic                           retire_valid_o,
  output rv_subset_pkg::retire_t         retire_o
);
  import rv_subset_pkg::*;

  // request: req up, wait for ack
  // release: req down, wait for ack to drop
  // execute: one cycle, write back and load pc
  typedef enum logic [1:0] {st_request, st_release, st_execute} state_e;

  state_e          state_q;
  logic            req_q;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] instr_q;
  logic            capture;

  // ack seen while req is up
  assign capture = (state_q == st_request) && req_q && imem_ack_i;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= st_request;
      req_q   <= 1'b0;
      pc_q    <= boot_addr;
    end else begin
      case (state_q)
        st_request: begin
          // first request after reset
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (capture) begin
            req_q   <= 1'b0;
            state_q <= st_release;
          end
        end
        st_release: begin
          if (!imem_ack_i) begin
            state_q <= st_execute;
          end
        end
        st_execute: begin
          // ack already low, next req may go up at once
          pc_q    <= res_i.next_pc;
          req_q   <= 1'b1;
          state_q <= st_request;
        end
        default: begin
          state_q <= st_request;
        end
      endcase
    end
  end

  // instruction word, loaded on the ack edge
  always_ff @(posedge clk_i) begin
    if (capture) begin
      instr_q <= imem_rdata_i;
    end
  end

  assign imem_req_o     = req_q;
  assign imem_addr_o    = pc_q;
  assign instr_o        = instr_q;
  assign pc_o           = pc_q;
  // x0 writes dropped here
  assign rf_we_o        = (state_q == st_execute) && res_i.wb_en && (dec_i.rd != '0);
  assign retire_valid_o = (state_q == st_execute);

  // trace record, wb_en is the write that really happened
  always_comb begin
    retire_o.pc      = pc_q;
    retire_o.instr   = instr_q;
    retire_o.rd      = dec_i.rd;
    retire_o.wb_en   = rf_we_o;
    retire_o.wb_data = res_i.wb_data;
    retire_o.next_pc = res_i.next_pc;
    retire_o.illegal = (dec_i.op == op_illegal);
  end

endmodule

//--- hw/rv_subset_core.sv
`timescale 1ns/1ps

module rv_subset_core (
  input  logic                           clk_i,
  input  logic                           rstn_i,
  output logic                           imem_req_o,
  output logic [rv_subset_pkg::xlen-1:0] imem_addr_o,
  input  logic                           imem_ack_i,
  input  logic [rv_subset_pkg::xlen-1:0] imem_rdata_i,
  output logic                           retire_valid_o,
  output rv_subset_pkg::retire_t         retire_o
);
  import rv_subset_pkg::*;

  // sequencer to datapath
  logic [xlen-1:0] instr;
  logic [xlen-1:0] pc;
  logic            rf_we;
  // datapath back to sequencer
  decoded_t        dec;
  exec_result_t    res;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  fetch_sequencer fetch_sequencer_i (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
    .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
    .instr_o(instr), .pc_o(pc), .dec_i(dec), .res_i(res), .rf_we_o(rf_we),
    .retire_valid_o(retire_valid_o), .retire_o(retire_o)
  );

  instr_decoder instr_decoder_i (.instr_i(instr), .dec_o(dec));

  exec_unit exec_unit_i (
    .dec_i(dec), .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .res_o(res)
  );

  // read addresses straight from decode, write in the execute cycle
  reg_file reg_file_i (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .we_i(rf_we), .waddr_i(dec.rd), .wdata_i(res.wb_data),
    .raddr1_i(dec.rs1), .raddr2_i(dec.rs2),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data)
  );

endmodule

//--- sim/rv_subset_props.sv
`timescale 1ns/1ps

module rv_subset_props (
  input logic clk_i,
  input logic rstn_i,
  input logic imem_req_o,
  input logic imem_ack_i,
  input logic retire_valid_o
);
  import rv_subset_pkg::*;

  // req only falls after ack was seen
  req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $fell(imem_req_o) |-> $past(imem_ack_i)) else $error("req dropped without ack");

  // a new request waits for ack low
  req_rise_ack_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $rose(imem_req_o) |-> !$past(imem_ack_i)) else $error("req raised while ack high");

  retire_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    retire_valid_o |=> !retire_valid_o) else $error("retire_valid held two cycles");

  // reset clears both outputs by the next edge
  reset_quiet: assert property (@(posedge clk_i)
    !rstn_i |=> (!imem_req_o && !retire_valid_o)) else $error("req or retire high after reset");

endmodule

bind rv_subset_core rv_subset_props rv_subset_props_i (
  .clk_i(clk_i), .rstn_i(rstn_i), .imem_req_o(imem_req_o),
  .imem_ack_i(imem_ack_i), .retire_valid_o(retire_valid_o)
);

//--- sim/tb_rv_subset_core.sv
`timescale 1ns/1ps

module tb_rv_subset_core;
  import rv_subset_pkg::*;

  logic            clk_i;
  logic            rstn_i;
  logic            imem_req_o;
  logic [xlen-1:0] imem_addr_o;
  logic            imem_ack_i;
  logic [xlen-1:0] imem_rdata_i;
  logic            retire_valid_o;
  retire_t         retire_o;

  // instruction memory word indexed by addr[9:2]
  logic [xlen-1:0] imem [256];
  logic [xlen-1:0] prog [$];
  // reference model state
  logic [xlen-1:0] model_regs [32];
  logic [xlen-1:0] model_pc;
  int              retired;
  // cycles left before the responder moves ack
  int              ack_wait;
  int              err_count;
  int              timeout_count;

  rv_subset_core rv_subset_core_i (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
    .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
    .retire_valid_o(retire_valid_o), .retire_o(retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opcode_alur};
  endfunction

  // addi and jalr share the i-type layout with funct3 000
  function automatic logic [31:0] enc_i(input logic [6:0] opc, input int rd, input int rs1,
                                        input int imm);
    return {12'(imm), 5'(rs1), funct3_addi, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_beq(input int rs1, input int rs2, input int off);
    logic [12:0] b;
    b = 13'(off);
    return {b[12], b[10:5], 5'(rs2), 5'(rs1), funct3_beq, b[4:1], b[11], opcode_branch};
  endfunction

  function automatic logic [31:0] enc_jal(input int rd, input int off);
    logic [20:0] j;
    j = 21'(off);
    return {j[20], j[10:1], j[11], j[19:12], 5'(rd), opcode_jal};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // model, memory responder and clock step
  //////////////////////////////////////////////////////////////////////

  // one retire pulse against the subset rules
  task automatic check_retire();
    logic [31:0] ins;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] wdata;
    logic [31:0] npc;
    logic        wr;
    logic        ill;
    ins   = imem[model_pc[9:2]];
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    wr    = 1'b1;
    ill   = 1'b0;
    // link value unless an alu op overrides it
    wdata = model_pc + 4;
    npc   = model_pc + 4;
    if (opc == opcode_alur && f7 == funct7_sub && f3 == funct3_add_sub) begin
      wdata = a - b;
    end else if (opc == opcode_alur && f7 == funct7_or && f3 == funct3_or) begin
      wdata = a | b;
    end else if (opc == opcode_alui && f3 == funct3_addi) begin
      wdata = a + imm_i;
    end else if (opc == opcode_branch && f3 == funct3_beq) begin
      wr = 1'b0;
      if (a == b) begin
        npc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
    end else if (opc == opcode_jal) begin
      npc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    end else if (opc == opcode_jalr) begin
      npc = (a + imm_i) & ~32'd1;
    end else begin
      wr  = 1'b0;
      ill = 1'b1;
    end
    // x0 never written
    wr = wr && (ins[11:7] != 5'd0);
    check_value("retire pc", retire_o.pc, model_pc);
    check_value("retire instr", retire_o.instr, ins);
    check_value("retire next_pc", retire_o.next_pc, npc);
    check_value("retire wb_en", 32'(retire_o.wb_en), 32'(wr));
    check_value("retire illegal", 32'(retire_o.illegal), 32'(ill));
    if (wr) begin
      check_value("retire rd", 32'(retire_o.rd), 32'(ins[11:7]));
      check_value("retire wb_data", retire_o.wb_data, wdata);
      model_regs[ins[11:7]] = wdata;
    end
    model_pc = npc;
    retired++;
  endtask

  // four-phase slave with ack rise and fall each delayed 0 to 3 cycles
  task automatic respond();
    if (!rstn_i) begin
      imem_ack_i = 1'b0;
      ack_wait   = 0;
    end else if (imem_req_o && !imem_ack_i) begin
      if (ack_wait == 0) begin
        imem_ack_i   = 1'b1;
        imem_rdata_i = imem[imem_addr_o[9:2]];
        ack_wait     = $urandom_range(3, 0);
      end else begin
        ack_wait--;
      end
    end else if (!imem_req_o && imem_ack_i) begin
      if (ack_wait == 0) begin
        imem_ack_i = 1'b0;
        ack_wait   = $urandom_range(3, 0);
      end else begin
        ack_wait--;
      end
    end
  endtask

  // each falling edge samples retire first and then drives the memory side
  task automatic tick();
    @(negedge clk_i);
    if (rstn_i && retire_valid_o) begin
      check_retire();
    end
    respond();
  endtask

  // reset, load prog into memory, clear the model, release
  task automatic start_program();
    tick();
    rstn_i = 1'b0;
    // unused words hold an illegal opcode tagged with their index
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : {25'(i), 7'h00};
    end
    prog.delete();
    repeat (3) begin
      tick();
      check_value("req in reset", 32'(imem_req_o), 32'd0);
      check_value("retire_valid in reset", 32'(retire_valid_o), 32'd0);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = boot_addr;
    retired  = 0;
    rstn_i   = 1'b1;
  endtask

  task automatic wait_retired(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (retired < count && cycles < limit) begin
      tick();
      cycles++;
    end
    if (retired < count) begin
      timeout_count++;
      $display("timeout: %0d of %0d instructions retired in %0d cycles", retired, count, limit);
    end
  endtask

  task automatic wait_pc(input logic [31:0] target, input int limit);
    int cycles;
    cycles = 0;
    while (model_pc != target && cycles < limit) begin
      tick();
      cycles++;
    end
    if (model_pc != target) begin
      timeout_count++;
      $display("timeout: pc %h not reached in %0d cycles", target, limit);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int cycles;
    prog.push_back(enc_i(opcode_alui, 1, 0, 1));
    start_program();
    cycles = 0;
    while (!imem_req_o && cycles < 10) begin
      tick();
      cycles++;
    end
    if (!imem_req_o) begin
      timeout_count++;
      $display("timeout: no fetch request after reset");
    end
    // req expected one clock after release
    check_value("cycles to first req", 32'(cycles), 32'd1);
    check_value("first fetch address", imem_addr_o, boot_addr);
    wait_retired(1, 20);
  endtask

  task automatic test_alu();
    prog.push_back(enc_i(opcode_alui, 1, 0, 5));
    prog.push_back(enc_i(opcode_alui, 2, 0, -3));
    prog.push_back(enc_r(funct7_sub, funct3_add_sub, 3, 1, 2));
    prog.push_back(enc_r(funct7_or, funct3_or, 4, 3, 2));
    prog.push_back(enc_i(opcode_alui, 5, 4, -2048));
    prog.push_back(enc_r(funct7_sub, funct3_add_sub, 6, 0, 1));
    prog.push_back(enc_r(funct7_or, funct3_or, 7, 6, 1));
    start_program();
    wait_retired(7, 100);
  endtask

  // forward taken, not taken, one backward loop pass
  task automatic test_branch();
    prog.push_back(enc_i(opcode_alui, 1, 0, 7));
    prog.push_back(enc_i(opcode_alui, 2, 0, 7));
    prog.push_back(enc_beq(1, 2, 12));
    prog.push_back(enc_i(opcode_alui, 9, 0, 1));
    prog.push_back(enc_i(opcode_alui, 9, 0, 2));
    prog.push_back(enc_i(opcode_alui, 6, 0, 1));
    prog.push_back(enc_i(opcode_alui, 3, 3, 1));
    prog.push_back(enc_beq(3, 6, -4));
    prog.push_back(enc_beq(1, 0, -32));
    start_program();
    wait_retired(9, 120);
  endtask

  // jalr sums 25 and 45 are odd
  task automatic test_jump();
    prog.push_back(enc_i(opcode_alui, 1, 0, 25));
    prog.push_back(enc_jal(2, 12));
    prog.push_back(enc_i(opcode_alui, 9, 0, 1));
    prog.push_back(enc_i(opcode_alui, 9, 0, 1));
    prog.push_back(enc_i(opcode_jalr, 3, 1, 0));
    prog.push_back(enc_i(opcode_alui, 9, 0, 1));
    prog.push_back(enc_i(opcode_alui, 5, 0, 40));
    prog.push_back(enc_i(opcode_jalr, 6, 5, 5));
    prog.push_back(enc_i(opcode_alui, 9, 0, 1));
    prog.push_back(enc_i(opcode_alui, 8, 0, 3));
    prog.push_back(enc_i(opcode_alui, 10, 0, 4));
    prog.push_back(enc_jal(7, -8));
    start_program();
    wait_retired(8, 120);
  endtask

  task automatic test_x0_illegal();
    prog.push_back(enc_i(opcode_alui, 0, 0, 55));
    prog.push_back(enc_r(funct7_or, funct3_or, 1, 0, 0));
    prog.push_back(enc_i(opcode_alui, 2, 0, 9));
    // add is outside the subset
    prog.push_back(enc_r(7'h00, funct3_add_sub, 5, 2, 2));
    prog.push_back(32'hffff_ffff);
    prog.push_back(enc_r(funct7_sub, funct3_add_sub, 6, 0, 2));
    start_program();
    wait_retired(6, 100);
  endtask

  // 48 random alu ops and forward branches over x0..x7
  task automatic test_random_program();
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    for (int i = 0; i < 48; i++) begin
      kind = $urandom_range(3, 0);
      rd   = $urandom_range(7, 0);
      rs1  = $urandom_range(7, 0);
      rs2  = $urandom_range(7, 0);
      imm  = $urandom_range(4095, 0);
      if (kind == 0 || (kind == 3 && i >= 47)) begin
        prog.push_back(enc_i(opcode_alui, rd, rs1, imm));
      end else if (kind == 1) begin
        prog.push_back(enc_r(funct7_sub, funct3_add_sub, rd, rs1, rs2));
      end else if (kind == 2) begin
        prog.push_back(enc_r(funct7_or, funct3_or, rd, rs1, rs2));
      end else begin
        prog.push_back(enc_beq(rs1, rs2, 8));
      end
    end
    start_program();
    wait_pc(32'd192, 1000);
  endtask

  initial begin
    rstn_i        = 1'b0;
    imem_ack_i    = 1'b0;
    imem_rdata_i  = '0;
    model_pc      = boot_addr;
    retired       = 0;
    ack_wait      = 0;
    err_count     = 0;
    timeout_count = 0;
    void'($urandom(44866));
    test_reset();
    test_alu();
    test_branch();
    test_jump();
    test_x0_illegal();
    test_random_program();
    $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sources.f
hw/rv_subset_pkg.sv
hw/instr_decoder.sv
hw/exec_unit.sv
hw/reg_file.sv
hw/fetch_sequencer.sv
hw/rv_subset_core.sv
sim/rv_subset_props.sv
sim/tb_rv_subset_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_subset_core
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
